// ==== filelist.f ====
led_ctrl_pkg.sv
ram_write_if.sv
command_decoder.sv
pixel_loader.sv
panel_blanker.sv
ram_write_arbiter.sv
led_matrix_ctrl.sv
tb_clock_gen.sv
tb_led_matrix_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module tb_led_matrix_ctrl -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_led_matrix_ctrl)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "All checks passed"; then
    exit 0
fi
echo "simulation did not report success"
exit 1

// ==== tb_led_matrix_ctrl.sv ====
module tb_led_matrix_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    // blank sweep needs about 4100 cycles and the rest well under 500
    localparam int cycle_limit = 12000;
    localparam int frame_bytes = 4096;

    logic clk_in;
    logic reset;
    logic [7:0] data_rx;
    logic data_ready_n;
    logic [2:0] rgb_enable;
    logic [5:0] brightness_enable;
    logic [11:0] ram_address;
    logic [7:0] ram_data_out;
    logic ram_write_enable;
    logic busy;
    logic ready_for_data;

    int cycle_count = 0;
    int last_accept_cycle = 0;
    int error_count = 0;
    int test_count = 0;
    logic [31:0] rng_state = 32'd85;
    logic [11:0] mon_addr[$];
    logic [7:0] mon_data[$];
    int mon_cycle[$];

    tb_clock_gen clock_gen (.clk_in(clk_in), .reset(reset));

    led_matrix_ctrl dut (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_address       (ram_address),
        .ram_data_out      (ram_data_out),
        .ram_write_enable  (ram_write_enable),
        .busy              (busy),
        .ready_for_data    (ready_for_data)
    );

    always @(posedge clk_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    // sampled mid-cycle so each write cycle gives one entry
    always @(negedge clk_in) begin
        if (ram_write_enable === 1'b1) begin
            mon_addr.push_back(ram_address);
            mon_data.push_back(ram_data_out);
            mon_cycle.push_back(cycle_count);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        error_count++;
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
    endtask

    task automatic end_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d failed checks", name, error_count - errors_before);
    endtask

    task automatic clear_monitor();
        mon_addr.delete();
        mon_data.delete();
        mon_cycle.delete();
    endtask

    // one-cycle strobe accepted on the rising edge in between
    task automatic send_byte(input logic [7:0] value);
        @(negedge clk_in);
        while (!ready_for_data) @(negedge clk_in);
        data_rx = value;
        data_ready_n = 1'b0;
        @(negedge clk_in);
        data_ready_n = 1'b1;
        last_accept_cycle = cycle_count;
    endtask

    task automatic test_reset_state();
        int errors_before;
        errors_before = error_count;
        if (rgb_enable !== 3'h7)
            report_mismatch("rgb_enable", rgb_enable, 3'h7);
        if (brightness_enable !== 6'h3f)
            report_mismatch("brightness_enable", brightness_enable, 6'h3f);
        if (ram_write_enable !== 1'b0)
            report_mismatch("ram_write_enable", ram_write_enable, 1'b0);
        if (ram_address !== 12'h000)
            report_mismatch("ram_address", ram_address, 12'h000);
        if (ram_data_out !== 8'h00)
            report_mismatch("ram_data_out", ram_data_out, 8'h00);
        if (busy !== 1'b0)
            report_mismatch("busy", busy, 1'b0);
        if (ready_for_data !== 1'b1)
            report_mismatch("ready_for_data", ready_for_data, 1'b1);
        end_test("reset state", errors_before);
    endtask

    task automatic test_colour_commands();
        logic [7:0] cmds [6];
        logic [2:0] model;
        int errors_before;
        errors_before = error_count;
        cmds = '{"r", "g", "b", "R", "G", "B"};
        model = 3'b111;
        for (int i = 0; i < 6; i++) begin
            send_byte(cmds[i]);
            model[i % 3] = (i >= 3);
            if (rgb_enable !== model)
                report_mismatch($sformatf("rgb_enable after %c", cmds[i]), rgb_enable, model);
        end
        send_byte("x");
        if (rgb_enable !== model)
            report_mismatch("rgb_enable after x", rgb_enable, model);
        if (brightness_enable !== 6'h3f)
            report_mismatch("brightness_enable after x", brightness_enable, 6'h3f);
        if (busy !== 1'b0)
            report_mismatch("busy after x", busy, 1'b0);
        end_test("colour commands", errors_before);
    endtask

    task automatic test_brightness_commands();
        logic [5:0] model;
        logic [7:0] value;
        int n;
        int errors_before;
        errors_before = error_count;
        model = 6'h3f;
        // digits 1 to 6 in order and then six more at random
        for (int i = 0; i < 12; i++) begin
            rng_state = xorshift(rng_state);
            n = (i < 6) ? i + 1 : int'(rng_state % 6) + 1;
            send_byte(8'h30 + 8'(n));
            model[6 - n] = ~model[6 - n];
            if (brightness_enable !== model)
                report_mismatch($sformatf("brightness_enable after %0d", n),
                                brightness_enable, model);
        end
        send_byte("0");
        if (brightness_enable !== 6'h00)
            report_mismatch("brightness_enable after 0", brightness_enable, 6'h00);
        send_byte("9");
        if (brightness_enable !== 6'h3f)
            report_mismatch("brightness_enable after 9", brightness_enable, 6'h3f);
        for (int i = 0; i < 3; i++) begin
            rng_state = xorshift(rng_state);
            value = rng_state[7:0];
            send_byte("T");
            if (busy !== 1'b1)
                report_mismatch("busy after T", busy, 1'b1);
            send_byte(value);
            if (brightness_enable !== value[5:0])
                report_mismatch("brightness_enable after T", brightness_enable, value[5:0]);
            if (busy !== 1'b0)
                report_mismatch("busy after T argument", busy, 1'b0);
        end
        end_test("brightness commands", errors_before);
    endtask

    task automatic pixel_command();
        logic [4:0] row;
        logic [5:0] col;
        logic [2:0] row_pad;
        logic [1:0] col_pad;
        logic [7:0] first_byte;
        logic [7:0] second_byte;
        logic [11:0] base;
        int first_cycle;
        rng_state = xorshift(rng_state);
        {col_pad, row_pad, second_byte, first_byte, col, row} = rng_state;
        base = 12'(row * 128 + col * 2);
        clear_monitor();
        send_byte("P");
        // random padding above the row and column fields
        send_byte({row_pad, row});
        send_byte({col_pad, col});
        send_byte(first_byte);
        first_cycle = last_accept_cycle;
        send_byte(second_byte);
        while (busy) @(negedge clk_in);
        @(negedge clk_in);
        if (mon_addr.size() != 2) begin
            error_count++;
            $display("pixel at row %0d col %0d gave %0d RAM writes instead of 2",
                     row, col, mon_addr.size());
        end else begin
            if (mon_addr[0] !== base + 12'd1)
                report_mismatch("ram_address", mon_addr[0], base + 12'd1);
            if (mon_data[0] !== first_byte)
                report_mismatch("ram_data_out", mon_data[0], first_byte);
            if (mon_addr[1] !== base)
                report_mismatch("ram_address", mon_addr[1], base);
            if (mon_data[1] !== second_byte)
                report_mismatch("ram_data_out", mon_data[1], second_byte);
            if (mon_cycle[0] != first_cycle || mon_cycle[1] != last_accept_cycle) begin
                error_count++;
                $display("pixel writes did not follow their data bytes by one cycle");
            end
        end
    endtask

    task automatic test_pixel_writes();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < 8; i++) begin
            pixel_command();
        end
        end_test("pixel writes", errors_before);
    endtask

    task automatic test_panel_blank();
        int errors_before;
        int start_cycle;
        int bad;
        errors_before = error_count;
        clear_monitor();
        send_byte("Z");
        start_cycle = last_accept_cycle;
        if (busy !== 1'b1)
            report_mismatch("busy after Z", busy, 1'b1);
        if (ready_for_data !== 1'b0)
            report_mismatch("ready_for_data after Z", ready_for_data, 1'b0);
        while (busy) @(negedge clk_in);
        @(negedge clk_in);
        bad = -1;
        for (int i = 0; i < mon_addr.size() && bad < 0; i++) begin
            if (mon_addr[i] !== 12'(i) || mon_data[i] !== 8'h00
                || mon_cycle[i] != start_cycle + i)
                bad = i;
        end
        if (mon_addr.size() != frame_bytes) begin
            error_count++;
            $display("panel blank made %0d RAM writes instead of %0d",
                     mon_addr.size(), frame_bytes);
        end else if (bad >= 0) begin
            if (mon_addr[bad] !== 12'(bad))
                report_mismatch("ram_address", mon_addr[bad], bad);
            if (mon_data[bad] !== 8'h00)
                report_mismatch("ram_data_out", mon_data[bad], 8'h00);
            if (mon_cycle[bad] != start_cycle + bad) begin
                error_count++;
                $display("blank write %0d was not in the cycle after the previous one", bad);
            end
        end
        if (busy !== 1'b0)
            report_mismatch("busy after blank", busy, 1'b0);
        if (ready_for_data !== 1'b1)
            report_mismatch("ready_for_data after blank", ready_for_data, 1'b1);
        pixel_command();
        end_test("panel blank", errors_before);
    endtask

    initial begin
        data_rx = 8'h00;
        data_ready_n = 1'b1;
        @(negedge reset);
        @(negedge clk_in);
        test_reset_state();
        test_colour_commands();
        test_brightness_commands();
        test_pixel_writes();
        test_panel_blank();
        $display("tests run: %0d, failed checks: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk_in,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    // held for two rising edges and released between edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;
    end

endmodule

// ==== led_matrix_ctrl.sv ====
module led_matrix_ctrl (
    input  logic                      clk_in,
    input  logic                      reset,
    input  led_ctrl_pkg::pixel_byte_t data_rx,
    input  logic                      data_ready_n,
    output logic [2:0]                rgb_enable,
    output led_ctrl_pkg::brightness_t brightness_enable,
    output led_ctrl_pkg::ram_addr_t   ram_address,
    output led_ctrl_pkg::pixel_byte_t ram_data_out,
    output logic                      ram_write_enable,
    output logic                      busy,
    output logic                      ready_for_data
);

    led_ctrl_pkg::pixel_byte_t loader_byte;
    logic loader_strobe;
    logic loader_done;
    logic blank_start;
    logic blank_done;

    ram_write_if blank_bus ();
    ram_write_if pixel_bus ();

    command_decoder u_decoder (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .loader_done       (loader_done),
        .blank_done        (blank_done),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .busy              (busy),
        .ready_for_data    (ready_for_data),
        .loader_byte       (loader_byte),
        .loader_strobe     (loader_strobe),
        .blank_start       (blank_start)
    );

    pixel_loader u_loader (
        .clk_in      (clk_in),
        .reset       (reset),
        .byte_in     (loader_byte),
        .byte_strobe (loader_strobe),
        .done        (loader_done),
        .ram         (pixel_bus.requester)
    );

    panel_blanker u_blanker (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (blank_start),
        .done   (blank_done),
        .ram    (blank_bus.requester)
    );

    ram_write_arbiter u_arbiter (
        .blank_port       (blank_bus.arbiter),
        .pixel_port       (pixel_bus.arbiter),
        .ram_address      (ram_address),
        .ram_data_out     (ram_data_out),
        .ram_write_enable (ram_write_enable)
    );

endmodule

// ==== ram_write_arbiter.sv ====
module ram_write_arbiter (
    ram_write_if.arbiter              blank_port,
    ram_write_if.arbiter              pixel_port,
    output led_ctrl_pkg::ram_addr_t   ram_address,
    output led_ctrl_pkg::pixel_byte_t ram_data_out,
    output logic                      ram_write_enable
);

    // blanker wins over the pixel loader
    assign blank_port.grant = blank_port.request;
    assign pixel_port.grant = pixel_port.request && !blank_port.request;

    always_comb begin
        ram_address = '0;
        ram_data_out = '0;
        ram_write_enable = 1'b0;
        if (blank_port.request) begin
            ram_address = blank_port.address;
            ram_data_out = blank_port.data;
            ram_write_enable = 1'b1;
        end else if (pixel_port.request) begin
            ram_address = pixel_port.address;
            ram_data_out = pixel_port.data;
            ram_write_enable = 1'b1;
        end
    end

endmodule

// ==== panel_blanker.sv ====
module panel_blanker (
    input  logic           clk_in,
    input  logic           reset,
    input  logic           start,
    output logic           done,
    ram_write_if.requester ram
);

    logic active;
    led_ctrl_pkg::ram_addr_t count;
    logic last_addr;

    assign last_addr = (count == led_ctrl_pkg::ram_addr_t'(led_ctrl_pkg::ram_depth - 1));

    assign ram.request = active;
    assign ram.address = count;
    assign ram.data = '0;

    assign done = active && ram.grant && last_addr;

    // one address per granted cycle
    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            active <= 1'b0;
            count <= '0;
        end else if (start) begin
            active <= 1'b1;
            count <= '0;
        end else if (active && ram.grant) begin
            if (last_addr) begin
                active <= 1'b0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// ==== pixel_loader.sv ====
module pixel_loader (
    input  logic                      clk_in,
    input  logic                      reset,
    input  led_ctrl_pkg::pixel_byte_t byte_in,
    input  logic                      byte_strobe,
    output logic                      done,
    ram_write_if.requester            ram
);

    // 0 row, 1 column, 2 first data byte, 3 second data byte
    logic [1:0] seq;
    logic request;
    logic second;
    logic [led_ctrl_pkg::row_bits-1:0] row_reg;
    logic [led_ctrl_pkg::col_bits-1:0] col_reg;
    led_ctrl_pkg::pixel_byte_t data_reg;
    logic [led_ctrl_pkg::byte_sel_bits-1:0] byte_sel;

    // first data byte lands at index 1
    assign byte_sel = second ? led_ctrl_pkg::byte_sel_bits'(0)
                             : led_ctrl_pkg::byte_sel_bits'(1);

    assign ram.request = request;
    assign ram.address = {row_reg, col_reg, byte_sel};
    assign ram.data = data_reg;

    assign done = request && ram.grant && second;

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            seq <= 2'd0;
            request <= 1'b0;
            second <= 1'b0;
        end else begin
            if (ram.grant) begin
                request <= 1'b0;
            end
            if (done) begin
                seq <= 2'd0;
                second <= 1'b0;
            end
            if (byte_strobe) begin
                case (seq)
                    2'd0: seq <= 2'd1;
                    2'd1: seq <= 2'd2;
                    2'd2: begin
                        seq <= 2'd3;
                        request <= 1'b1;
                        second <= 1'b0;
                    end
                    default: begin
                        request <= 1'b1;
                        second <= 1'b1;
                    end
                endcase
            end
        end
    end

    // upper bits of row and column bytes are dropped
    always_ff @(posedge clk_in) begin
        if (byte_strobe) begin
            case (seq)
                2'd0: row_reg <= byte_in[led_ctrl_pkg::row_bits-1:0];
                2'd1: col_reg <= byte_in[led_ctrl_pkg::col_bits-1:0];
                default: data_reg <= byte_in;
            endcase
        end
    end

endmodule

// ==== command_decoder.sv ====
module command_decoder (
    input  logic                      clk_in,
    input  logic                      reset,
    input  led_ctrl_pkg::pixel_byte_t data_rx,
    input  logic                      data_ready_n,
    input  logic                      loader_done,
    input  logic                      blank_done,
    output logic [2:0]                rgb_enable,
    output led_ctrl_pkg::brightness_t brightness_enable,
    output logic                      busy,
    output logic                      ready_for_data,
    output led_ctrl_pkg::pixel_byte_t loader_byte,
    output logic                      loader_strobe,
    output logic                      blank_start
);

    led_ctrl_pkg::cmd_state_t state;
    led_ctrl_pkg::opcode_t opcode;
    logic accept;

    assign opcode = led_ctrl_pkg::opcode_t'(data_rx);

    // bytes are dropped while the blanker owns the bus
    assign ready_for_data = (state != led_ctrl_pkg::cmd_blank_panel);
    assign busy = (state != led_ctrl_pkg::cmd_idle);
    assign accept = ~data_ready_n && ready_for_data;

    assign loader_byte = data_rx;
    assign loader_strobe = accept && (state == led_ctrl_pkg::cmd_write_pixel);

    // fires on the accepting cycle so the sweep starts right after
    assign blank_start = accept && (state == led_ctrl_pkg::cmd_idle)
                         && (opcode == led_ctrl_pkg::op_blank);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state <= led_ctrl_pkg::cmd_idle;
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
        end else begin
            case (state)
                led_ctrl_pkg::cmd_idle: begin
                    if (accept) begin
                        case (opcode)
                            led_ctrl_pkg::op_red_on: rgb_enable[0] <= 1'b1;
                            led_ctrl_pkg::op_red_off: rgb_enable[0] <= 1'b0;
                            led_ctrl_pkg::op_green_on: rgb_enable[1] <= 1'b1;
                            led_ctrl_pkg::op_green_off: rgb_enable[1] <= 1'b0;
                            led_ctrl_pkg::op_blue_on: rgb_enable[2] <= 1'b1;
                            led_ctrl_pkg::op_blue_off: rgb_enable[2] <= 1'b0;
                            // digit n flips bit (levels - n) so digit 1 is the msb
                            led_ctrl_pkg::op_bright_1: begin
                                brightness_enable[5] <= ~brightness_enable[5];
                            end
                            led_ctrl_pkg::op_bright_2: begin
                                brightness_enable[4] <= ~brightness_enable[4];
                            end
                            led_ctrl_pkg::op_bright_3: begin
                                brightness_enable[3] <= ~brightness_enable[3];
                            end
                            led_ctrl_pkg::op_bright_4: begin
                                brightness_enable[2] <= ~brightness_enable[2];
                            end
                            led_ctrl_pkg::op_bright_5: begin
                                brightness_enable[1] <= ~brightness_enable[1];
                            end
                            led_ctrl_pkg::op_bright_6: begin
                                brightness_enable[0] <= ~brightness_enable[0];
                            end
                            led_ctrl_pkg::op_bright_clear: brightness_enable <= '0;
                            led_ctrl_pkg::op_bright_set: brightness_enable <= '1;
                            led_ctrl_pkg::op_bright_load: begin
                                state <= led_ctrl_pkg::cmd_read_brightness;
                            end
                            led_ctrl_pkg::op_blank: state <= led_ctrl_pkg::cmd_blank_panel;
                            led_ctrl_pkg::op_pixel: state <= led_ctrl_pkg::cmd_write_pixel;
                            default: begin
                            end
                        endcase
                    end
                end
                led_ctrl_pkg::cmd_read_brightness: begin
                    if (accept) begin
                        brightness_enable <= data_rx[led_ctrl_pkg::brightness_levels-1:0];
                        state <= led_ctrl_pkg::cmd_idle;
                    end
                end
                led_ctrl_pkg::cmd_blank_panel: begin
                    if (blank_done) begin
                        state <= led_ctrl_pkg::cmd_idle;
                    end
                end
                led_ctrl_pkg::cmd_write_pixel: begin
                    if (loader_done) begin
                        state <= led_ctrl_pkg::cmd_idle;
                    end
                end
                default: state <= led_ctrl_pkg::cmd_idle;
            endcase
        end
    end

endmodule

// ==== ram_write_if.sv ====
interface ram_write_if;

    logic request;
    led_ctrl_pkg::ram_addr_t address;
    led_ctrl_pkg::pixel_byte_t data;
    logic grant;

    // request, address and data held until grant
    modport requester (
        output request,
        output address,
        output data,
        input  grant
    );

    modport arbiter (
        input  request,
        input  address,
        input  data,
        output grant
    );

endinterface

// ==== led_ctrl_pkg.sv ====
package led_ctrl_pkg;

    // panel geometry
    localparam int panel_width = 64;
    localparam int panel_height = 32;
    localparam int bytes_per_pixel = 2;
    localparam int brightness_levels = 6;

    // frame address fields
    localparam int row_bits = $clog2(panel_height);
    localparam int col_bits = $clog2(panel_width);
    localparam int byte_sel_bits = $clog2(bytes_per_pixel);
    localparam int ram_addr_bits = row_bits + col_bits + byte_sel_bits;
    localparam int ram_depth = panel_width * panel_height * bytes_per_pixel;

    // row high, then column, then byte select
    typedef logic [ram_addr_bits-1:0] ram_addr_t;
    typedef logic [7:0] pixel_byte_t;
    typedef logic [brightness_levels-1:0] brightness_t;

    // ascii command characters
    typedef enum logic [7:0] {
        op_bright_clear = 8'h30,
        op_bright_1     = 8'h31,
        op_bright_2     = 8'h32,
        op_bright_3     = 8'h33,
        op_bright_4     = 8'h34,
        op_bright_5     = 8'h35,
        op_bright_6     = 8'h36,
        op_bright_set   = 8'h39,
        op_blue_on      = 8'h42,
        op_green_on     = 8'h47,
        op_pixel        = 8'h50,
        op_red_on       = 8'h52,
        op_bright_load  = 8'h54,
        op_blank        = 8'h5A,
        op_blue_off     = 8'h62,
        op_green_off    = 8'h67,
        op_red_off      = 8'h72
    } opcode_t;

    typedef enum logic [1:0] {
        cmd_idle,
        cmd_read_brightness,
        cmd_blank_panel,
        cmd_write_pixel
    } cmd_state_t;

endpackage
